//--- sim_defines.svh
`ifndef SIM_DEFINES_SVH
`define SIM_DEFINES_SVH

// number of point masses in the rope
`define NODE_COUNT 4

// max spacing between neighbours on each axis, 10.0 in q16.16
`define REST_LEN 32'sh000A_0000

// y acceleration added once per step, 0.3 in q16.16
`define GRAVITY_Y 32'sh0000_4CCC

// reset x of every node and of the anchor, 200.0 in q16.16
`define BASE_X 32'sh00C8_0000

// output credits the host grants after reset
`define OUT_CREDITS 4

// command credits the host holds after reset
`define CMD_CREDITS 1

`endif

//--- src/rope_pkg.sv
package rope_pkg;

    // signed q16.16 word, 16 integer bits and 16 fraction bits
    typedef logic signed [31:0] fix_t;

    // alu function select
    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_MUL
    } alu_op_t;

    // host commands
    typedef enum logic {
        CMD_STEP,
        CMD_SET_ANCHOR
    } cmd_op_t;

    // controller phases
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_VERLET,
        ST_CONSTRAIN,
        ST_REPORT,
        ST_DONE
    } ctrl_state_t;

endpackage

//--- src/fixed_alu.sv
`timescale 1ns/10ps

module fixed_alu (
    input  rope_pkg::fix_t    a,
    input  rope_pkg::fix_t    b,
    input  rope_pkg::alu_op_t op,
    output rope_pkg::fix_t    result
);
    import rope_pkg::*;

    // sign extended operands so the product keeps all 64 bits
    logic signed [63:0] a_wide;
    logic signed [63:0] b_wide;
    logic signed [63:0] product;

    assign a_wide = a;
    assign b_wide = b;

    // full signed product, 32.32 fixed point
    assign product = a_wide * b_wide;

    always_comb begin
        case (op)
            ALU_ADD: begin
                // wraps modulo 2^32
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_MUL: begin
                // dropping the low 16 bits floors toward minus infinity
                result = product[47:16];
            end
            default: begin
                result = a + b;
            end
        endcase
    end

endmodule

//--- src/node_ctrl_if.sv
`timescale 1ns/10ps
`include "sim_defines.svh"

interface node_ctrl_if;
    import rope_pkg::*;

    localparam int IDX_W = $clog2(`NODE_COUNT);

    // one cycle verlet update of every node
    logic verlet_en;

    // constraint write to a single node
    logic             fix_en;
    logic [IDX_W-1:0] fix_sel;
    fix_t             fix_x;
    fix_t             fix_y;

    // current positions, one slot per node
    fix_t pos_x [`NODE_COUNT];
    fix_t pos_y [`NODE_COUNT];

    // controller starts verlet phase and reads positions for the report
    modport ctrl (
        output verlet_en,
        input  pos_x, pos_y
    );

    // solver reads positions and writes one node per cycle
    modport solver (
        output fix_en, fix_sel, fix_x, fix_y,
        input  pos_x, pos_y
    );

    // each node takes the enables and drives its own position slot
    modport node (
        input  verlet_en, fix_en, fix_sel, fix_x, fix_y,
        output pos_x, pos_y
    );

endinterface

//--- src/verlet_node.sv
`timescale 1ns/10ps
`include "sim_defines.svh"

module verlet_node #(
    parameter int node_id = 0
) (
    input logic       clk,
    input logic       reset,
    node_ctrl_if.node bus
);
    import rope_pkg::*;

    localparam int   IDX_W  = $clog2(`NODE_COUNT);
    localparam fix_t TWO    = 32'sh0002_0000;
    // nodes start hanging straight down, one rest length apart
    localparam fix_t INIT_Y = fix_t'(`REST_LEN * node_id);

    fix_t x;
    fix_t y;
    fix_t prev_x;
    fix_t prev_y;
    fix_t x_dbl;
    fix_t y_dbl;
    fix_t x_next;
    fix_t y_verlet;
    fix_t y_next;
    logic selected;

    // next = 2*pos - prev on each axis
    fixed_alu u_x_dbl (.a(x), .b(TWO), .op(ALU_MUL), .result(x_dbl));
    fixed_alu u_x_sub (.a(x_dbl), .b(prev_x), .op(ALU_SUB), .result(x_next));
    fixed_alu u_y_dbl (.a(y), .b(TWO), .op(ALU_MUL), .result(y_dbl));
    fixed_alu u_y_sub (.a(y_dbl), .b(prev_y), .op(ALU_SUB), .result(y_verlet));

    // gravity pulls along +y only
    assign y_next = y_verlet + `GRAVITY_Y;

    assign selected = bus.fix_en && (bus.fix_sel == IDX_W'(node_id));

    always_ff @(posedge clk) begin
        if (reset) begin
            // at rest, so prev equals pos
            x      <= `BASE_X;
            y      <= INIT_Y;
            prev_x <= `BASE_X;
            prev_y <= INIT_Y;
        end else if (bus.verlet_en) begin
            prev_x <= x;
            prev_y <= y;
            x      <= x_next;
            y      <= y_next;
        end else if (selected) begin
            // constraint moves pos only, velocity carries over through prev
            x <= bus.fix_x;
            y <= bus.fix_y;
        end
    end

    assign bus.pos_x[node_id] = x;
    assign bus.pos_y[node_id] = y;

endmodule

//--- src/constraint_solver.sv
`timescale 1ns/10ps
`include "sim_defines.svh"

module constraint_solver (
    input  logic           clk,
    input  logic           reset,
    node_ctrl_if.solver    bus,
    input  logic           solve_start,
    output logic           solve_done,
    input  rope_pkg::fix_t anchor_x,
    input  rope_pkg::fix_t anchor_y
);
    import rope_pkg::*;

    localparam int               IDX_W     = $clog2(`NODE_COUNT);
    localparam logic [IDX_W-1:0] LAST_NODE = IDX_W'(`NODE_COUNT - 1);

    logic             busy;
    logic [IDX_W-1:0] node_cnt;
    // already fixed position of node node_cnt-1
    fix_t             prev_x;
    fix_t             prev_y;
    fix_t             dx;
    fix_t             dy;

    // limit one axis offset to +/- rest length
    function automatic fix_t clamp_axis(input fix_t d);
        fix_t lim;
        lim = `REST_LEN;
        if (d > lim) begin
            return lim;
        end else if (d < -lim) begin
            return -lim;
        end
        return d;
    endfunction

    // offset of the current node from its fixed predecessor
    fixed_alu u_dx (.a(bus.pos_x[node_cnt]), .b(prev_x), .op(ALU_SUB), .result(dx));
    fixed_alu u_dy (.a(bus.pos_y[node_cnt]), .b(prev_y), .op(ALU_SUB), .result(dy));

    always_comb begin
        bus.fix_en  = busy;
        bus.fix_sel = node_cnt;
        if (node_cnt == '0) begin
            // node 0 is pinned to the anchor
            bus.fix_x = anchor_x;
            bus.fix_y = anchor_y;
        end else begin
            bus.fix_x = prev_x + clamp_axis(dx);
            bus.fix_y = prev_y + clamp_axis(dy);
        end
    end

    // done comes together with the last write
    assign solve_done = busy && (node_cnt == LAST_NODE);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            node_cnt <= '0;
        end else if (busy) begin
            node_cnt <= node_cnt + 1'b1;
            if (node_cnt == LAST_NODE) begin
                busy     <= 1'b0;
                node_cnt <= '0;
            end
        end else if (solve_start) begin
            busy     <= 1'b1;
            node_cnt <= '0;
        end
    end

    // keep the value just written so the next node clamps against it
    always_ff @(posedge clk) begin
        if (busy) begin
            prev_x <= bus.fix_x;
            prev_y <= bus.fix_y;
        end
    end

endmodule

//--- src/sim_controller.sv
`timescale 1ns/10ps
`include "sim_defines.svh"

module sim_controller (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            cmd_valid,
    input  rope_pkg::cmd_op_t               cmd_op,
    input  rope_pkg::fix_t                  cmd_x,
    input  rope_pkg::fix_t                  cmd_y,
    output logic                            cmd_credit,
    output logic                            out_valid,
    output logic [$clog2(`NODE_COUNT)-1:0]  out_node,
    output rope_pkg::fix_t                  out_x,
    output rope_pkg::fix_t                  out_y,
    output logic                            out_last,
    input  logic                            out_credit,
    node_ctrl_if.ctrl                       bus,
    output logic                            solve_start,
    input  logic                            solve_done,
    output rope_pkg::fix_t                  anchor_x,
    output rope_pkg::fix_t                  anchor_y
);
    import rope_pkg::*;

    localparam int               IDX_W     = $clog2(`NODE_COUNT);
    localparam int               CRD_W     = $clog2(`OUT_CREDITS + 1);
    localparam logic [IDX_W-1:0] LAST_NODE = IDX_W'(`NODE_COUNT - 1);

    ctrl_state_t      state;
    logic [IDX_W-1:0] rpt_idx;
    // output credits the host has granted and not yet received beats for
    logic [CRD_W-1:0] out_cnt;

    // one cycle update right after a step is taken
    assign bus.verlet_en = (state == ST_VERLET);

    // report beat only when a credit is available
    assign out_valid = (state == ST_REPORT) && (out_cnt != '0);
    assign out_last  = out_valid && (rpt_idx == LAST_NODE);
    assign out_node  = rpt_idx;
    assign out_x     = bus.pos_x[rpt_idx];
    assign out_y     = bus.pos_y[rpt_idx];

    // every command ends by passing through done
    assign cmd_credit = (state == ST_DONE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= ST_IDLE;
            solve_start <= 1'b0;
            rpt_idx     <= '0;
            anchor_x    <= `BASE_X;
            anchor_y    <= '0;
        end else begin
            solve_start <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (cmd_valid) begin
                        if (cmd_op == CMD_SET_ANCHOR) begin
                            anchor_x <= cmd_x;
                            anchor_y <= cmd_y;
                            state    <= ST_DONE;
                        end else begin
                            state <= ST_VERLET;
                        end
                    end
                end
                ST_VERLET: begin
                    // solver starts the cycle after the update
                    solve_start <= 1'b1;
                    state       <= ST_CONSTRAIN;
                end
                ST_CONSTRAIN: begin
                    if (solve_done) begin
                        rpt_idx <= '0;
                        state   <= ST_REPORT;
                    end
                end
                ST_REPORT: begin
                    // holds here while out of credits
                    if (out_valid) begin
                        rpt_idx <= rpt_idx + 1'b1;
                        if (rpt_idx == LAST_NODE) begin
                            state <= ST_DONE;
                        end
                    end
                end
                ST_DONE: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // spend on a beat, refill on a returned credit, both may happen together
    always_ff @(posedge clk) begin
        if (reset) begin
            out_cnt <= CRD_W'(`OUT_CREDITS);
        end else begin
            case ({out_valid, out_credit})
                2'b10: out_cnt <= out_cnt - 1'b1;
                2'b01: out_cnt <= out_cnt + 1'b1;
                default: out_cnt <= out_cnt;
            endcase
        end
    end

endmodule

//--- src/rope_sim_top.sv
`timescale 1ns/10ps
`include "sim_defines.svh"

module rope_sim_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            cmd_valid,
    input  rope_pkg::cmd_op_t               cmd_op,
    input  rope_pkg::fix_t                  cmd_x,
    input  rope_pkg::fix_t                  cmd_y,
    output logic                            cmd_credit,
    output logic                            out_valid,
    output logic [$clog2(`NODE_COUNT)-1:0]  out_node,
    output rope_pkg::fix_t                  out_x,
    output rope_pkg::fix_t                  out_y,
    output logic                            out_last,
    input  logic                            out_credit
);
    import rope_pkg::*;

    logic solve_start;
    logic solve_done;
    fix_t anchor_x;
    fix_t anchor_y;

    // enables, constraint writes and positions shared by the blocks below
    node_ctrl_if bus ();

    sim_controller u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_x       (cmd_x),
        .cmd_y       (cmd_y),
        .cmd_credit  (cmd_credit),
        .out_valid   (out_valid),
        .out_node    (out_node),
        .out_x       (out_x),
        .out_y       (out_y),
        .out_last    (out_last),
        .out_credit  (out_credit),
        .bus         (bus.ctrl),
        .solve_start (solve_start),
        .solve_done  (solve_done),
        .anchor_x    (anchor_x),
        .anchor_y    (anchor_y)
    );

    constraint_solver u_solver (
        .clk         (clk),
        .reset       (reset),
        .bus         (bus.solver),
        .solve_start (solve_start),
        .solve_done  (solve_done),
        .anchor_x    (anchor_x),
        .anchor_y    (anchor_y)
    );

    // the rope itself, node 0 at the anchor end
    for (genvar i = 0; i < `NODE_COUNT; i++) begin : g_node
        verlet_node #(.node_id(i)) u_node (
            .clk   (clk),
            .reset (reset),
            .bus   (bus.node)
        );
    end

endmodule

//--- tests/rope_sim_assertions.sv
`timescale 1ns/10ps
`include "sim_defines.svh"

module rope_sim_assertions (
    input logic                  clk,
    input logic                  reset,
    input logic                  cmd_valid,
    input rope_pkg::cmd_op_t     cmd_op,
    input logic                  cmd_credit,
    input logic                  out_valid,
    input logic                  out_credit,
    input rope_pkg::fix_t        out_x,
    input rope_pkg::fix_t        out_y,
    input rope_pkg::ctrl_state_t state
);
    import rope_pkg::*;

    // high from command acceptance until its credit goes back
    logic cmd_open;
    // credits handed over by the host and not yet spent on a beat
    int   granted;

    always_ff @(posedge clk) begin
        if (reset) begin
            cmd_open <= 1'b0;
        end else if (cmd_valid && (state == ST_IDLE)) begin
            cmd_open <= 1'b1;
        end else if (cmd_credit) begin
            cmd_open <= 1'b0;
        end
    end

    // host side view of the output credits
    always_ff @(posedge clk) begin
        if (reset) begin
            granted <= `OUT_CREDITS;
        end else begin
            granted <= granted + int'(out_credit) - int'(out_valid);
        end
    end

    // a report beat always spends a granted credit
    beat_needs_credit: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> (granted > 0))
        else $error("out_valid raised with no output credit left");

    // command credit only closes a command that was taken
    credit_needs_command: assert property (@(posedge clk) disable iff (reset)
        cmd_credit |-> cmd_open)
        else $error("cmd_credit pulsed with no command outstanding");

    // a taken step gives exactly one cycle of verlet update, one cycle later
    verlet_one_cycle: assert property (@(posedge clk) disable iff (reset)
        (cmd_valid && (cmd_op == CMD_STEP) && !cmd_open)
            |=> (state == ST_VERLET) ##1 (state != ST_VERLET))
        else $error("verlet update missing or held longer than one cycle");

    report_known: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> !$isunknown({out_x, out_y}))
        else $error("unknown position on a report beat");

endmodule

//--- tests/rope_sim_tb.sv
`timescale 1ns/10ps
`include "sim_defines.svh"

module rope_sim_tb;
    import rope_pkg::*;

    localparam int          IDX_W     = $clog2(`NODE_COUNT);
    localparam logic [31:0] LFSR_SEED = 32'h38cb;
    // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    localparam string       CASE_FILE = "tests/rope_cases.txt";

    logic             clk;
    logic             reset;
    logic             cmd_valid;
    cmd_op_t          cmd_op;
    fix_t             cmd_x;
    fix_t             cmd_y;
    logic             cmd_credit;
    logic             out_valid;
    logic [IDX_W-1:0] out_node;
    fix_t             out_x;
    fix_t             out_y;
    logic             out_last;
    logic             out_credit;

    // commands and the expected report of every step, in file order
    int   case_op [$];
    fix_t case_x [$];
    fix_t case_y [$];
    fix_t file_x [$];
    fix_t file_y [$];
    // beats still expected from the step in flight
    fix_t exp_x [$];
    fix_t exp_y [$];

    int          errors;
    int          checks;
    int          cycles;
    int          cycle_limit;
    int          host_credits;
    int          model_out_credits;
    int          step_beats;
    int          cmd_credits_seen;
    int          owed;
    int          wait_cnt;
    int          exp_node;
    logic [31:0] lfsr;
    fix_t        last_x;
    fix_t        last_y;

    always #10 clk = ~clk;

    rope_sim_top UUT (
        .clk        (clk),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_x      (cmd_x),
        .cmd_y      (cmd_y),
        .cmd_credit (cmd_credit),
        .out_valid  (out_valid),
        .out_node   (out_node),
        .out_x      (out_x),
        .out_y      (out_y),
        .out_last   (out_last),
        .out_credit (out_credit)
    );

    bind sim_controller rope_sim_assertions u_sva (
        .clk        (clk),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_credit (cmd_credit),
        .out_valid  (out_valid),
        .out_credit (out_credit),
        .out_x      (out_x),
        .out_y      (out_y),
        .state      (state)
    );

    // one galois shift, the bit taken is the lsb before the shift
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ LFSR_TAPS;
        end
        return n;
    endfunction

    // command lines carry op x y, each step line is followed by the node positions
    task automatic load_cases();
        int          fd;
        int          n;
        int          want;
        int          op;
        int          pending;
        logic [31:0] a;
        logic [31:0] b;
        string       line;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the case file %s", CASE_FILE);
            return;
        end
        pending = 0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if ((n == 0) || (line.len() < 2) || (line[0] == "#")) begin
                continue;
            end
            if (pending > 0) begin
                want = 2;
                n = $sscanf(line, "%h %h", a, b);
                file_x.push_back(a);
                file_y.push_back(b);
                pending--;
            end else begin
                want = 3;
                n = $sscanf(line, "%d %h %h", op, a, b);
                case_op.push_back(op);
                case_x.push_back(a);
                case_y.push_back(b);
                if (op == 0) begin
                    pending = `NODE_COUNT;
                end
            end
            if (n != want) begin
                errors++;
                $display("malformed line in the case file: %s", line);
            end
        end
        $fclose(fd);
    endtask

    task automatic check_beat();
        fix_t ex;
        fix_t ey;
        fix_t dx;
        fix_t dy;
        step_beats++;
        if (model_out_credits == 0) begin
            errors++;
            $display("report beat sent while the host had granted no credit");
        end else begin
            model_out_credits--;
        end
        if (exp_x.size() == 0) begin
            errors++;
            $display("report beat arrived with no step in flight");
            return;
        end
        ex = exp_x.pop_front();
        ey = exp_y.pop_front();
        checks++;
        if (out_node !== IDX_W'(exp_node)) begin
            errors++;
            $display("ERR out_node expected %h got %h", IDX_W'(exp_node), out_node);
        end
        if (out_x !== ex) begin
            errors++;
            $display("ERR out_x node %0d expected %h got %h", exp_node, ex, out_x);
        end
        if (out_y !== ey) begin
            errors++;
            $display("ERR out_y node %0d expected %h got %h", exp_node, ey, out_y);
        end
        if (out_last !== (exp_node == `NODE_COUNT - 1)) begin
            errors++;
            $display("ERR out_last node %0d expected %h got %h", exp_node,
                     (exp_node == `NODE_COUNT - 1), out_last);
        end
        // neighbours stay inside the per-axis rest length
        dx = out_x - last_x;
        dy = out_y - last_y;
        if ((exp_node > 0) && ((dx > `REST_LEN) || (dx < -`REST_LEN) ||
                               (dy > `REST_LEN) || (dy < -`REST_LEN))) begin
            errors++;
            $display("node %0d lies more than the rest length from its neighbour", exp_node);
        end
        last_x = out_x;
        last_y = out_y;
        exp_node = (exp_node + 1) % `NODE_COUNT;
    endtask

    task automatic finish_run();
        $display("beats checked: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    // host side of both credit channels, plus the watchdog
    always @(posedge clk) begin
        if (reset) begin
            out_credit <= 1'b0;
            owed = 0;
            wait_cnt = -1;
        end else begin
            cycles++;
            out_credit <= 1'b0;
            if (cmd_credit) begin
                cmd_credits_seen++;
                host_credits++;
                if (host_credits > `CMD_CREDITS) begin
                    errors++;
                    $display("command credit came back with no command outstanding");
                end
            end
            // beat first, so a credit arriving this cycle cannot cover it
            if (out_valid) begin
                check_beat();
                owed++;
            end
            if (out_credit) begin
                model_out_credits++;
            end
            // random 0 to 3 cycle delay before each returned credit
            if ((wait_cnt < 0) && (owed > 0)) begin
                wait_cnt = 0;
                for (int b = 0; b < 2; b++) begin
                    wait_cnt = (wait_cnt << 1) | int'(lfsr[0]);
                    lfsr = lfsr_next(lfsr);
                end
            end
            if (wait_cnt == 0) begin
                out_credit <= 1'b1;
                owed--;
                wait_cnt = -1;
            end else if (wait_cnt > 0) begin
                wait_cnt--;
            end
            if (cycles > cycle_limit) begin
                errors++;
                $display("timeout, the run did not finish within %0d cycles", cycle_limit);
                finish_run();
            end
        end
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        cmd_valid = 1'b0;
        cmd_op = CMD_STEP;
        cmd_x = '0;
        cmd_y = '0;
        out_credit = 1'b0;
        errors = 0;
        checks = 0;
        cycles = 0;
        host_credits = `CMD_CREDITS;
        model_out_credits = `OUT_CREDITS;
        cmd_credits_seen = 0;
        step_beats = 0;
        exp_node = 0;
        last_x = '0;
        last_y = '0;
        lfsr = LFSR_SEED;
        load_cases();
        cycle_limit = case_op.size() * (`NODE_COUNT * 5 + 10);
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        foreach (case_op[i]) begin
            while (host_credits == 0) begin
                @(posedge clk);
            end
            if (case_op[i] == 0) begin
                for (int k = 0; k < `NODE_COUNT; k++) begin
                    exp_x.push_back(file_x.pop_front());
                    exp_y.push_back(file_y.pop_front());
                end
                step_beats = 0;
            end
            cmd_valid <= 1'b1;
            cmd_op <= cmd_op_t'(case_op[i]);
            cmd_x <= case_x[i];
            cmd_y <= case_y[i];
            host_credits--;
            @(posedge clk);
            cmd_valid <= 1'b0;
            @(posedge clk);
            // next command only once this one has handed its credit back
            while (host_credits == 0) begin
                @(posedge clk);
            end
            if ((case_op[i] == 0) && (step_beats != `NODE_COUNT)) begin
                errors++;
                $display("step %0d ended after %0d report beats", i, step_beats);
            end
        end
        repeat (4) @(posedge clk);
        if (cmd_credits_seen != case_op.size()) begin
            errors++;
            $display("%0d command credits seen for %0d commands", cmd_credits_seen,
                     case_op.size());
        end
        finish_run();
    end

endmodule

//--- tests/rope_cases.txt
# command line: op x y, op 0 is STEP and 1 is SET_ANCHOR, x and y are q16.16 hex
# each STEP line is followed by one expected x y line per node, node 0 first
0 00000000 00000000
00C80000 00000000
00C80000 000A0000
00C80000 00140000
00C80000 001E0000
0 00000000 00000000
00C80000 00000000
00C80000 000A0000
00C80000 00140000
00C80000 001E0000
1 00FA0000 FFEC0000
0 00000000 00000000
00FA0000 FFEC0000
00F00000 FFF60000
00E60000 00000000
00DC0000 000A0000
0 00000000 00000000
00FA0000 FFEC0000
01040000 FFE24CCC
01040000 FFEC4CCC
00FA0000 FFF64CCC
1 00960000 00640000
0 00000000 00000000
00960000 00640000
00A00000 005A0000
00AA0000 00500000
00B40000 00460000
0 00000000 00000000
00960000 00640000
008C0000 006E0000
00820000 00780000
00780000 00820000

//--- sim.f
+incdir+.
src/rope_pkg.sv
src/fixed_alu.sv
src/node_ctrl_if.sv
src/verlet_node.sv
src/constraint_solver.sv
src/sim_controller.sv
src/rope_sim_top.sv
tests/rope_sim_assertions.sv
tests/rope_sim_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the rope simulator testbench with verilator, run it and scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module rope_sim_tb -o rope_sim_tb

./obj_dir/rope_sim_tb | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation reported failures, see sim.log"
    exit 1
fi
echo "simulation finished without failures"
